/* compile.f */
conv_pim_pkg.sv
pim_macro.sv
conv5x5_pim.sv
axil_conv_regs.sv
pim_conv_top.sv
tb_pim_conv.sv

/* tb_pim_conv.sv */
`timescale 1ns/1ps
// Self-checking testbench that drives pim_conv_top over AXI4-Lite against a plain dot-product model
module tb_pim_conv import conv_pim_pkg::*;
();

	// About 60 convolutions of some 40 transactions each plus margin
	localparam int max_cycles = 40000;
	localparam int poll_limit = 20;

	logic                     clk;
	logic                     rst;
	logic [axi_addr_bits-1:0] awaddr;
	logic                     awvalid;
	logic                     awready;
	logic [axi_data_bits-1:0] wdata;
	logic [axi_strb_bits-1:0] wstrb;
	logic                     wvalid;
	logic                     wready;
	logic [1:0]               bresp;
	logic                     bvalid;
	logic                     bready;
	logic [axi_addr_bits-1:0] araddr;
	logic                     arvalid;
	logic                     arready;
	logic [axi_data_bits-1:0] rdata;
	logic [1:0]               rresp;
	logic                     rvalid;
	logic                     rready;

	logic [31:0]         rng_state;
	logic [pix_bits-1:0] win_m [taps];
	logic [pix_bits-1:0] kern_m [kernel_count][taps];
	int unsigned         sel_m;
	int                  mismatch_errors;
	int                  other_errors;
	int                  cycle_count = 0;

	pim_conv_top i_dut (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Expected read data of a window word with one pixel per byte
	function automatic logic [31:0] window_word_model(input int word);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 4; i++)
		begin
			if (word * 4 + i < taps)
			begin
				w[i*8 +: pix_bits] = win_m[word*4 + i];
			end
		end
		return w;
	endfunction

	function automatic int unsigned conv_model(input int unsigned sel);
		int unsigned sum;
		sum = 0;
		for (int t = 0; t < taps; t++)
		begin
			sum = sum + win_m[t] * kern_m[sel][t];
		end
		return sum;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		mismatch_errors++;
	endtask

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		logic aw_done;
		logic w_done;
		logic aw_fire;
		logic w_fire;
		int hold;
		aw_done = 1'b0;
		w_done = 1'b0;
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		wvalid = 1'b1;
		while (!(aw_done && w_done))
		begin
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			next_cycle();
			if (aw_fire)
			begin
				awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_fire)
			begin
				wvalid = 1'b0;
				w_done = 1'b1;
			end
		end
		// Back-pressure on the response
		hold = rand_word() % 4;
		repeat (hold) next_cycle();
		bready = 1'b1;
		while (!bvalid) next_cycle();
		resp = bresp;
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		logic ar_fire;
		int hold;
		araddr = addr;
		arvalid = 1'b1;
		ar_fire = 1'b0;
		while (!ar_fire)
		begin
			ar_fire = arvalid && arready;
			next_cycle();
		end
		arvalid = 1'b0;
		hold = rand_word() % 4;
		repeat (hold) next_cycle();
		rready = 1'b1;
		while (!rvalid) next_cycle();
		data = rdata;
		resp = rresp;
		next_cycle();
		rready = 1'b0;
	endtask

	task automatic check_read(input string name, input logic [11:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		if (resp !== resp_okay)
		begin
			report_mismatch({name, " response"}, resp_okay, resp);
		end
		if (data !== exp)
		begin
			report_mismatch(name, exp, data);
		end
	endtask

	task automatic write_window(input int word, input logic [31:0] data, input logic [3:0] strb);
		logic [1:0] resp;
		axi_write(reg_window_base + 12'(word * 4), data, strb, resp);
		if (resp !== resp_okay)
		begin
			report_mismatch("window write response", resp_okay, resp);
		end
		for (int i = 0; i < 4; i++)
		begin
			if (word * 4 + i < taps && strb[i])
			begin
				win_m[word*4 + i] = data[i*8 +: pix_bits];
			end
		end
	endtask

	task automatic write_kernel(input int k, input int word, input logic [31:0] data,
		input logic [3:0] strb);
		logic [1:0] resp;
		axi_write(reg_kernel_base + 12'(k * kernel_stride + word * 4), data, strb, resp);
		if (resp !== resp_okay)
		begin
			report_mismatch("kernel write response", resp_okay, resp);
		end
		for (int i = 0; i < 4; i++)
		begin
			if (word * 4 + i < taps && strb[i])
			begin
				kern_m[k][word*4 + i] = data[i*8 +: pix_bits];
			end
		end
	endtask

	// Start, poll status for done, then read and check the result
	task automatic run_conv(input string name, input int unsigned sel, output logic [31:0] got);
		logic [31:0] status;
		logic [1:0] resp;
		int polls;
		axi_write(reg_ctrl, (sel << ctrl_sel_lsb) | 32'h1, 4'b0011, resp);
		if (resp !== resp_okay)
		begin
			report_mismatch({name, " ctrl response"}, resp_okay, resp);
		end
		sel_m = sel;
		polls = 0;
		status = '0;
		while (!status[status_done_bit] && polls < poll_limit)
		begin
			axi_read(reg_status, status, resp);
			polls++;
		end
		if (!status[status_done_bit])
		begin
			$display("%s: status never showed done after %0d polls", name, polls);
			other_errors++;
		end
		if (status !== 32'h2)
		begin
			report_mismatch({name, " status"}, 32'h2, status);
		end
		axi_read(reg_result, got, resp);
		if (got !== conv_model(sel))
		begin
			report_mismatch(name, conv_model(sel), got);
		end
	endtask

	initial
	begin
		logic [axi_addr_bits-1:0] unmapped [6];
		logic [31:0] data;
		logic [31:0] got;
		logic [1:0] resp;
		int unsigned exp_prev [kernel_count];
		int unsigned sel;
		int k;
		int w;
		clk = 1'b0;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		rng_state = 32'hbee3ee97;
		mismatch_errors = 0;
		other_errors = 0;
		sel_m = 0;
		for (int t = 0; t < taps; t++)
		begin
			win_m[t] = '0;
			for (int j = 0; j < kernel_count; j++)
			begin
				kern_m[j][t] = '0;
			end
		end
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		// Reset state
		check_read("reset status", reg_status, 32'h0);
		check_read("reset result", reg_result, 32'h0);
		check_read("reset ctrl", reg_ctrl, 32'h0);
		for (int j = 0; j < win_words; j++)
		begin
			check_read("reset window", reg_window_base + 12'(j * 4), 32'h0);
		end

		// Window readback with full and partial strobes
		for (int j = 0; j < win_words; j++)
		begin
			write_window(j, rand_word(), 4'hf);
			check_read("window readback", reg_window_base + 12'(j * 4), window_word_model(j));
		end
		for (int n = 0; n < 14; n++)
		begin
			w = rand_word() % win_words;
			data = rand_word();
			write_window(w, data, rand_word() & 32'hf);
			check_read("window partial strobe", reg_window_base + 12'(w * 4),
				window_word_model(w));
		end

		// Random convolutions
		for (int run = 0; run < 40; run++)
		begin
			k = (run < kernel_count) ? run : rand_word() % kernel_count;
			for (int j = 0; j < win_words; j++)
			begin
				write_kernel(k, j, rand_word(), (run % 4 == 3) ? rand_word() & 32'hf : 4'hf);
			end
			for (int j = 0; j < win_words; j++)
			begin
				write_window(j, rand_word(), 4'hf);
			end
			sel = rand_word() % kernel_count;
			run_conv("random conv", sel, got);
			check_read("ctrl select", reg_ctrl, sel_m << ctrl_sel_lsb);
		end

		// Kernel independence
		for (int j = 0; j < kernel_count; j++)
		begin
			for (int i = 0; i < win_words; i++)
			begin
				write_kernel(j, i, rand_word(), 4'hf);
			end
		end
		for (int j = 0; j < win_words; j++)
		begin
			write_window(j, rand_word(), 4'hf);
		end
		for (int s = 0; s < kernel_count; s++)
		begin
			run_conv("kernel select", s, got);
			exp_prev[s] = conv_model(s);
		end
		for (int i = 0; i < win_words; i++)
		begin
			write_kernel(2, i, rand_word(), 4'hf);
		end
		for (int s = 0; s < kernel_count; s++)
		begin
			run_conv("kernel rewrite", s, got);
			if (s != 2 && got !== exp_prev[s])
			begin
				report_mismatch("kernel rewrite other select", exp_prev[s], got);
			end
		end

		// Extremes where 0xff bytes mask down to 63
		for (int j = 0; j < win_words; j++)
		begin
			write_window(j, 32'h3f3f3f3f, 4'hf);
			write_kernel(1, j, 32'hffffffff, 4'hf);
		end
		run_conv("all 63 max", 1, got);
		if (got !== 32'd99225)
		begin
			report_mismatch("max result", 32'd99225, got);
		end
		for (int j = 0; j < win_words; j++)
		begin
			write_window(j, 32'h0, 4'hf);
		end
		run_conv("zero window", 1, got);
		if (got !== 32'd0)
		begin
			report_mismatch("zero result", 32'd0, got);
		end

		// Address decoding
		for (int j = 0; j < win_words; j++)
		begin
			write_window(j, rand_word(), 4'hf);
		end
		run_conv("decode setup", rand_word() % 3, got);
		unmapped[0] = 12'h00c;
		unmapped[1] = 12'h03c;
		unmapped[2] = 12'h05c;
		unmapped[3] = 12'h0fc;
		unmapped[4] = 12'h180;
		unmapped[5] = 12'hffc;
		for (int j = 0; j < 6; j++)
		begin
			// Start bit and select 3 must not take effect
			axi_write(unmapped[j], 32'h0000_0301, 4'hf, resp);
			if (resp !== resp_slverr)
			begin
				report_mismatch("unmapped write response", resp_slverr, resp);
			end
			axi_read(unmapped[j], data, resp);
			if (resp !== resp_slverr)
			begin
				report_mismatch("unmapped read response", resp_slverr, resp);
			end
		end
		check_read("status after unmapped", reg_status, 32'h2);
		check_read("result after unmapped", reg_result, conv_model(sel_m));
		check_read("ctrl after unmapped", reg_ctrl, sel_m << ctrl_sel_lsb);
		for (int j = 0; j < win_words; j++)
		begin
			check_read("window after unmapped", reg_window_base + 12'(j * 4),
				window_word_model(j));
		end
		check_read("kernel region read", reg_kernel_base, 32'h0);
		check_read("kernel region read", reg_kernel_base + 12'h04c, 32'h0);
		write_kernel(0, 6, (rand_word() & 32'h3f) | 32'h3f3f3f00, 4'hf);
		write_window(6, 32'h3f3f3f00 | (rand_word() & 32'h3f), 4'hf);
		run_conv("word 6 upper lanes", 0, got);

		$display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* pim_conv_top.sv */
`timescale 1ns/1ps
// Top level of the PIM convolution engine, an AXI4-Lite register block driving the conv core
module pim_conv_top import conv_pim_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic [axi_addr_bits-1:0] awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  logic [axi_data_bits-1:0] wdata,
	input  logic [axi_strb_bits-1:0] wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	input  logic [axi_addr_bits-1:0] araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output logic [axi_data_bits-1:0] rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready
);

	logic [window_bits-1:0]      window;
	logic [kernel_sel_bits-1:0]  kernel_sel;
	logic                        start;
	logic                        weight_we;
	logic [kernel_sel_bits-1:0]  weight_kernel;
	logic [word_sel_bits-1:0]    weight_word;
	logic [weight_data_bits-1:0] weight_data;
	logic [lanes-1:0]            weight_lanes;
	logic [result_bits-1:0]      result;
	logic                        result_valid;

	axil_conv_regs u_regs (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.window(window), .kernel_sel(kernel_sel), .start(start),
		.weight_we(weight_we), .weight_kernel(weight_kernel), .weight_word(weight_word),
		.weight_data(weight_data), .weight_lanes(weight_lanes),
		.result(result), .result_valid(result_valid)
	);

	conv5x5_pim u_conv (
		.clk(clk), .rst(rst),
		.window(window), .kernel_sel(kernel_sel), .start(start),
		.weight_we(weight_we), .weight_kernel(weight_kernel), .weight_word(weight_word),
		.weight_data(weight_data), .weight_lanes(weight_lanes),
		.result(result), .result_valid(result_valid)
	);

endmodule

/* axil_conv_regs.sv */
`timescale 1ns/1ps
// AXI4-Lite slave with window, control, status and result registers; forwards kernel writes
module axil_conv_regs import conv_pim_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [axi_addr_bits-1:0]    awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [axi_data_bits-1:0]    wdata,
	input  logic [axi_strb_bits-1:0]    wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [axi_addr_bits-1:0]    araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [axi_data_bits-1:0]    rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output logic [window_bits-1:0]      window,
	output logic [kernel_sel_bits-1:0]  kernel_sel,
	output logic                        start,
	output logic                        weight_we,
	output logic [kernel_sel_bits-1:0]  weight_kernel,
	output logic [word_sel_bits-1:0]    weight_word,
	output logic [weight_data_bits-1:0] weight_data,
	output logic [lanes-1:0]            weight_lanes,
	input  logic [result_bits-1:0]      result,
	input  logic                        result_valid
);

	logic                     aw_held;
	logic                     w_held;
	logic [axi_addr_bits-1:0] aw_addr_q;
	logic [axi_data_bits-1:0] w_data_q;
	logic [axi_strb_bits-1:0] w_strb_q;
	logic                     wr_fire;

	logic [region_bits-1:0]   wr_region;
	logic [region_bits-1:0]   rd_region;
	logic [axi_addr_bits-1:0] wr_win_off;
	logic [axi_addr_bits-1:0] wr_ker_off;
	logic [axi_addr_bits-1:0] rd_win_off;
	logic [word_sel_bits-1:0] wr_win_word;
	logic [word_sel_bits-1:0] rd_win_word;
	logic [axi_data_bits-1:0] rd_data;

	pixel_u                   win_pix [taps];
	logic                     busy;
	logic                     done;
	logic [result_bits-1:0]   result_q;

	function automatic logic [region_bits-1:0] decode_region(input logic [axi_addr_bits-1:0] addr);
		logic [axi_addr_bits-1:0] win_off;
		logic [axi_addr_bits-1:0] ker_off;
		win_off = addr - reg_window_base;
		ker_off = addr - reg_kernel_base;
		if (addr[axi_addr_bits-1:2] == reg_ctrl[axi_addr_bits-1:2])
		begin
			return region_ctrl;
		end
		if (addr[axi_addr_bits-1:2] == reg_status[axi_addr_bits-1:2])
		begin
			return region_status;
		end
		if (addr[axi_addr_bits-1:2] == reg_result[axi_addr_bits-1:2])
		begin
			return region_result;
		end
		// Offsets below the base wrap high and fall out of range
		if (win_off < win_words * 4)
		begin
			return region_window;
		end
		if (ker_off < kernel_count * kernel_stride)
		begin
			return region_kernel;
		end
		return region_none;
	endfunction

	assign wr_region   = decode_region(aw_addr_q);
	assign rd_region   = decode_region(araddr);
	assign wr_win_off  = aw_addr_q - reg_window_base;
	assign wr_ker_off  = aw_addr_q - reg_kernel_base;
	assign rd_win_off  = araddr - reg_window_base;
	assign wr_win_word = wr_win_off[2 +: word_sel_bits];
	assign rd_win_word = rd_win_off[2 +: word_sel_bits];

	// Write takes effect once both channels are in, as bvalid rises
	assign wr_fire = aw_held && w_held && !bvalid;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			if (awvalid && awready)
			begin
				aw_held <= 1'b1;
				awready <= 1'b0;
			end
			else if (!aw_held)
			begin
				awready <= 1'b1;
			end
			if (wvalid && wready)
			begin
				w_held <= 1'b1;
				wready <= 1'b0;
			end
			else if (!w_held)
			begin
				wready <= 1'b1;
			end
			if (wr_fire)
			begin
				bvalid <= 1'b1;
			end
			else if (bvalid && bready)
			begin
				bvalid <= 1'b0;
				aw_held <= 1'b0;
				w_held <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (awvalid && awready)
		begin
			aw_addr_q <= awaddr;
		end
		if (wvalid && wready)
		begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
		if (wr_fire)
		begin
			bresp <= (wr_region == region_none) ? resp_slverr : resp_okay;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			kernel_sel <= '0;
			start <= 1'b0;
			weight_we <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			result_q <= '0;
			for (int t = 0; t < taps; t++)
			begin
				win_pix[t] <= '0;
			end
		end
		else
		begin
			start <= 1'b0;
			weight_we <= 1'b0;
			if (wr_fire && wr_region == region_ctrl)
			begin
				if (w_strb_q[ctrl_start_bit / 8] && w_data_q[ctrl_start_bit])
				begin
					start <= 1'b1;
				end
				if (w_strb_q[ctrl_sel_lsb / 8])
				begin
					kernel_sel <= w_data_q[ctrl_sel_lsb +: kernel_sel_bits];
				end
			end
			if (wr_fire && wr_region == region_window)
			begin
				for (int t = 0; t < taps; t++)
				begin
					if (t / lanes == wr_win_word && w_strb_q[t % lanes])
					begin
						win_pix[t].value <= w_data_q[(t % lanes)*8 +: pix_bits];
					end
				end
			end
			if (wr_fire && wr_region == region_kernel)
			begin
				weight_we <= 1'b1;
			end
			if (result_valid)
			begin
				result_q <= result;
				busy <= 1'b0;
				done <= 1'b1;
			end
			// A new start overrides a finishing one
			if (start)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_fire && wr_region == region_kernel)
		begin
			weight_kernel <= wr_ker_off[$clog2(kernel_stride) +: kernel_sel_bits];
			weight_word <= wr_ker_off[2 +: word_sel_bits];
			weight_lanes <= w_strb_q;
			for (int i = 0; i < lanes; i++)
			begin
				weight_data[i*pix_bits +: pix_bits] <= w_data_q[i*8 +: pix_bits];
			end
		end
	end

	always_comb
	begin
		for (int t = 0; t < taps; t++)
		begin
			window[t*pix_bits +: pix_bits] = win_pix[t].value;
		end
	end

	// Read mux, kernel region reads as zero
	always_comb
	begin
		rd_data = '0;
		case (rd_region)
			region_ctrl:
			begin
				rd_data[ctrl_sel_lsb +: kernel_sel_bits] = kernel_sel;
			end
			region_status:
			begin
				rd_data[status_busy_bit] = busy;
				rd_data[status_done_bit] = done;
			end
			region_result:
			begin
				rd_data[result_bits-1:0] = result_q;
			end
			region_window:
			begin
				for (int t = 0; t < taps; t++)
				begin
					if (t / lanes == rd_win_word)
					begin
						rd_data[(t % lanes)*8 +: pix_bits] = win_pix[t].value;
					end
				end
			end
			default:
			begin
				rd_data = '0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else if (arvalid && arready)
		begin
			arready <= 1'b0;
			rvalid <= 1'b1;
		end
		else
		begin
			if (!rvalid)
			begin
				arready <= 1'b1;
			end
			if (rvalid && rready)
			begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (arvalid && arready)
		begin
			rdata <= rd_data;
			rresp <= (rd_region == region_none) ? resp_slverr : resp_okay;
		end
	end

endmodule

/* conv5x5_pim.sv */
`timescale 1ns/1ps
// 5x5 convolution from four slice macros (HH, HL, LH, LL) and a shift-add combiner
module conv5x5_pim import conv_pim_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [window_bits-1:0]      window,
	input  logic [kernel_sel_bits-1:0]  kernel_sel,
	input  logic                        start,
	input  logic                        weight_we,
	input  logic [kernel_sel_bits-1:0]  weight_kernel,
	input  logic [word_sel_bits-1:0]    weight_word,
	input  logic [weight_data_bits-1:0] weight_data,
	input  logic [lanes-1:0]            weight_lanes,
	output logic [result_bits-1:0]      result,
	output logic                        result_valid
);

	pixel_u win_pix [taps];
	logic [slice_vec_bits-1:0] in_hi;
	logic [slice_vec_bits-1:0] in_lo;

	logic                        seq_active;
	logic [lane_bits-1:0]        seq_lane;
	logic [kernel_sel_bits-1:0]  hold_kernel;
	logic [word_sel_bits-1:0]    hold_word;
	logic [weight_data_bits-1:0] hold_data;
	logic [lanes-1:0]            hold_lanes;

	logic [lane_bits-1:0]        wr_lane;
	logic [kernel_sel_bits-1:0]  wr_kernel;
	logic [word_sel_bits-1:0]    wr_word;
	logic [weight_data_bits-1:0] wr_data;
	logic [lanes-1:0]            wr_lanes;
	logic [tap_bits-1:0]         wr_tap;
	logic                        wr_en;
	pixel_u                      wr_weight;

	logic [macro_out_bits-1:0] dot_hh;
	logic [macro_out_bits-1:0] dot_hl;
	logic [macro_out_bits-1:0] dot_lh;
	logic [macro_out_bits-1:0] dot_ll;
	logic start_q;

	// Input slice vectors
	always_comb
	begin
		for (int t = 0; t < taps; t++)
		begin
			win_pix[t] = window[t*pix_bits +: pix_bits];
			in_hi[t*slice_bits +: slice_bits] = win_pix[t].slices.hi;
			in_lo[t*slice_bits +: slice_bits] = win_pix[t].slices.lo;
		end
	end

	// Macros take one tap per cycle: lane 0 goes straight through,
	// lanes 1 to 3 are replayed from the held word
	assign wr_lane   = weight_we ? '0 : seq_lane;
	assign wr_kernel = weight_we ? weight_kernel : hold_kernel;
	assign wr_word   = weight_we ? weight_word : hold_word;
	assign wr_data   = weight_we ? weight_data : hold_data;
	assign wr_lanes  = weight_we ? weight_lanes : hold_lanes;
	assign wr_tap    = {wr_word, wr_lane};
	assign wr_weight = wr_data[wr_lane*pix_bits +: pix_bits];
	assign wr_en     = (weight_we || seq_active) && wr_lanes[wr_lane] && (wr_tap < taps);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			seq_active <= 1'b0;
			seq_lane <= '0;
		end
		else if (weight_we)
		begin
			seq_active <= 1'b1;
			seq_lane <= lane_bits'(1);
		end
		else if (seq_active)
		begin
			seq_lane <= seq_lane + 1'b1;
			if (seq_lane == lane_bits'(lanes - 1))
			begin
				seq_active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (weight_we)
		begin
			hold_kernel <= weight_kernel;
			hold_word <= weight_word;
			hold_data <= weight_data;
			hold_lanes <= weight_lanes;
		end
	end

	pim_macro macro_hh (
		.clk(clk), .rst(rst), .we(wr_en), .wr_kernel(wr_kernel), .wr_tap(wr_tap),
		.wr_slice(wr_weight.slices.hi), .kernel_sel(kernel_sel), .start(start),
		.in_slices(in_hi), .dot(dot_hh)
	);

	pim_macro macro_hl (
		.clk(clk), .rst(rst), .we(wr_en), .wr_kernel(wr_kernel), .wr_tap(wr_tap),
		.wr_slice(wr_weight.slices.lo), .kernel_sel(kernel_sel), .start(start),
		.in_slices(in_hi), .dot(dot_hl)
	);

	pim_macro macro_lh (
		.clk(clk), .rst(rst), .we(wr_en), .wr_kernel(wr_kernel), .wr_tap(wr_tap),
		.wr_slice(wr_weight.slices.hi), .kernel_sel(kernel_sel), .start(start),
		.in_slices(in_lo), .dot(dot_lh)
	);

	pim_macro macro_ll (
		.clk(clk), .rst(rst), .we(wr_en), .wr_kernel(wr_kernel), .wr_tap(wr_tap),
		.wr_slice(wr_weight.slices.lo), .kernel_sel(kernel_sel), .start(start),
		.in_slices(in_lo), .dot(dot_ll)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			start_q <= 1'b0;
			result_valid <= 1'b0;
		end
		else
		begin
			start_q <= start;
			result_valid <= start_q;
		end
	end

	// (8h + l)(8h' + l') = 64hh' + 8(hl' + lh') + ll'
	always_ff @(posedge clk)
	begin
		if (start_q)
		begin
			result <= (result_bits'(dot_hh) << (2 * slice_bits))
				+ (result_bits'(dot_hl) << slice_bits)
				+ (result_bits'(dot_lh) << slice_bits)
				+ result_bits'(dot_ll);
		end
	end

endmodule

/* pim_macro.sv */
`timescale 1ns/1ps
// One PIM crossbar holding 3-bit weight slices of four kernels; registers a slice dot product on start
module pim_macro import conv_pim_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       we,
	input  logic [kernel_sel_bits-1:0] wr_kernel,
	input  logic [tap_bits-1:0]        wr_tap,
	input  logic [slice_bits-1:0]      wr_slice,
	input  logic [kernel_sel_bits-1:0] kernel_sel,
	input  logic                       start,
	input  logic [slice_vec_bits-1:0]  in_slices,
	output logic [macro_out_bits-1:0]  dot
);

	// One row per kernel, one cell per tap
	logic [slice_bits-1:0] cells [kernel_count][taps];
	logic [macro_out_bits-1:0] col_sum;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < kernel_count; k++)
			begin
				for (int t = 0; t < taps; t++)
				begin
					cells[k][t] <= '0;
				end
			end
		end
		else if (we)
		begin
			cells[wr_kernel][wr_tap] <= wr_slice;
		end
	end

	// Column accumulate of the selected row
	always_comb
	begin
		col_sum = '0;
		for (int t = 0; t < taps; t++)
		begin
			col_sum = col_sum + in_slices[t*slice_bits +: slice_bits] * cells[kernel_sel][t];
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			dot <= col_sum;
		end
	end

endmodule

/* conv_pim_pkg.sv */
// Sizes, register map and pixel type of the PIM convolution engine, imported by RTL and testbench
package conv_pim_pkg;

	// Data sizes
	localparam int pix_bits = 6;
	localparam int slice_bits = 3;
	localparam int taps = 25;
	localparam int kernel_count = 4;
	localparam int kernel_sel_bits = 2;
	localparam int win_words = 7;
	localparam int macro_out_bits = 11;
	localparam int result_bits = 18;
	localparam int window_bits = taps * pix_bits;
	localparam int slice_vec_bits = taps * slice_bits;
	localparam int tap_bits = 5;

	// Four pixels per 32-bit word, one per byte lane
	localparam int lanes = 4;
	localparam int lane_bits = 2;
	localparam int word_sel_bits = 3;
	localparam int weight_data_bits = lanes * pix_bits;

	// AXI4-Lite
	localparam int axi_addr_bits = 12;
	localparam int axi_data_bits = 32;
	localparam int axi_strb_bits = axi_data_bits / 8;
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Register byte offsets
	localparam logic [axi_addr_bits-1:0] reg_ctrl = 12'h000;
	localparam logic [axi_addr_bits-1:0] reg_status = 12'h004;
	localparam logic [axi_addr_bits-1:0] reg_result = 12'h008;
	localparam logic [axi_addr_bits-1:0] reg_window_base = 12'h040;
	localparam logic [axi_addr_bits-1:0] reg_kernel_base = 12'h100;
	localparam int kernel_stride = 32;

	// Field positions
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_sel_lsb = 8;
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;

	// Address decode results
	localparam int region_bits = 3;
	localparam logic [region_bits-1:0] region_none = 3'd0;
	localparam logic [region_bits-1:0] region_ctrl = 3'd1;
	localparam logic [region_bits-1:0] region_status = 3'd2;
	localparam logic [region_bits-1:0] region_result = 3'd3;
	localparam logic [region_bits-1:0] region_window = 3'd4;
	localparam logic [region_bits-1:0] region_kernel = 3'd5;

	// A pixel or weight, seen whole or as hi/lo slices
	typedef union packed {
		logic [pix_bits-1:0] value;
		struct packed {
			logic [slice_bits-1:0] hi;
			logic [slice_bits-1:0] lo;
		} slices;
	} pixel_u;

endpackage
